// File: proc_pkg.sv
// Shared types, instruction encodings and control/status structs
// for the five-stage pipelined processor

package proc_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // --------------------------------------------------
  // Opcodes and function codes
  // --------------------------------------------------

  localparam logic [5:0] op_special = 6'h00;
  localparam logic [5:0] op_j       = 6'h02;
  localparam logic [5:0] op_bne     = 6'h05;
  localparam logic [5:0] op_addiu   = 6'h09;
  localparam logic [5:0] op_ori     = 6'h0d;
  localparam logic [5:0] op_lui     = 6'h0f;
  localparam logic [5:0] op_cop0    = 6'h10;
  localparam logic [5:0] op_mul     = 6'h1c;
  localparam logic [5:0] op_lw      = 6'h23;
  localparam logic [5:0] op_sw      = 6'h2b;

  localparam logic [5:0] fn_sll  = 6'h00;
  localparam logic [5:0] fn_jr   = 6'h08;
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_slt  = 6'h2a;

  // rs field of a cop0 instruction picks the direction
  localparam logic [4:0] cop0_mf = 5'h00;
  localparam logic [4:0] cop0_mt = 5'h04;

  // --------------------------------------------------
  // Select encodings
  // --------------------------------------------------

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_sll, alu_lui
  } alu_fn_t;

  typedef enum logic [1:0] {op0_rs, op0_shamt, op0_zero} op0_sel_t;

  typedef enum logic [2:0] {
    op1_rt, op1_simm, op1_zimm, op1_pc4, op1_mngr
  } op1_sel_t;

  typedef enum logic [1:0] {byp_none, byp_x, byp_m, byp_w} byp_sel_t;

  typedef enum logic [1:0] {pc_plus4, pc_br, pc_j, pc_jr} pc_sel_t;

  // --------------------------------------------------
  // Control and status between ctrl and dpath
  // --------------------------------------------------

  typedef struct packed {
    logic      reg_en_f;
    logic      reg_en_d;
    logic      reg_en_x;
    logic      reg_en_m;
    logic      reg_en_w;
    logic      squash_d;
    pc_sel_t   pc_sel;
    op0_sel_t  op0_sel;
    op1_sel_t  op1_sel;
    byp_sel_t  byp_rs;
    byp_sel_t  byp_rt;
    alu_fn_t   alu_fn;
    logic      ex_sel_mul;
    logic      wb_sel_mem;
    reg_addr_t rf_waddr;
    logic      rf_wen;
  } ctrl_to_dpath_t;

  typedef struct packed {
    word_t inst_d;
    logic  br_ne_x;
  } dpath_to_ctrl_t;

endpackage

// File: proc_alu.sv
// Processor ALU for the X stage, with the not-equal flag used by bne

`timescale 1ns/1ns

module proc_alu (
  input  proc_pkg::word_t   in0,
  input  proc_pkg::word_t   in1,
  input  proc_pkg::alu_fn_t fn,
  output proc_pkg::word_t   out,
  output logic              ne
);

  import proc_pkg::*;

  always_comb begin
    case (fn)
      alu_add: out = in0 + in1;
      alu_sub: out = in0 - in1;
      alu_and: out = in0 & in1;
      alu_or:  out = in0 | in1;
      alu_slt: out = {31'b0, $signed(in0) < $signed(in1)};
      // Shift amount arrives on in0
      alu_sll: out = in1 << in0[4:0];
      alu_lui: out = {in1[15:0], 16'b0};
      default: out = '0;
    endcase
  end

  assign ne = (in0 != in1);

endmodule

// File: proc_regfile.sv
// 32 x 32-bit register file, two combinational reads and one write
// Register zero always reads as zero

`timescale 1ns/1ns

module proc_regfile (
  input  logic                clk,
  input  logic                reset,
  input  proc_pkg::reg_addr_t raddr0,
  input  proc_pkg::reg_addr_t raddr1,
  input  proc_pkg::reg_addr_t waddr,
  output proc_pkg::word_t     rdata0,
  output proc_pkg::word_t     rdata1,
  input  logic                wen,
  input  proc_pkg::word_t     wdata
);

  import proc_pkg::*;

  word_t regs [0:31];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  // Write-through covers an instruction in D reading what W writes
  function automatic word_t read_port(reg_addr_t addr, word_t stored, logic wr_en,
                                      reg_addr_t wr_addr, word_t wr_data);
    if (addr == '0)
      return '0;
    if (wr_en && (addr == wr_addr))
      return wr_data;
    return stored;
  endfunction

  assign rdata0 = read_port(raddr0, regs[raddr0], wen, waddr, wdata);
  assign rdata1 = read_port(raddr1, regs[raddr1], wen, waddr, wdata);

endmodule

// File: proc_int_mul.sv
// Iterative shift-and-add multiplier, one bit per cycle
// Returns the low 32 bits of the product through a valid/ready response

`timescale 1ns/1ns

module proc_int_mul (
  input  logic            clk,
  input  logic            reset,
  input  logic            req_val,
  output logic            req_rdy,
  input  proc_pkg::word_t req_a,
  input  proc_pkg::word_t req_b,
  output logic            resp_val,
  input  logic            resp_rdy,
  output proc_pkg::word_t resp_data
);

  import proc_pkg::*;

  typedef enum logic [1:0] {st_idle, st_calc, st_done} state_t;

  state_t     state;
  word_t      a_reg;
  word_t      b_reg;
  word_t      acc;
  logic [4:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (req_val) state <= st_calc;
        st_calc: if (count == 5'd31) state <= st_done;
        st_done: if (resp_rdy) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // Operands load while idle, then one partial product per cycle
  always_ff @(posedge clk) begin
    case (state)
      st_idle: begin
        a_reg <= req_a;
        b_reg <= req_b;
        acc   <= '0;
        count <= '0;
      end
      st_calc: begin
        if (b_reg[0])
          acc <= acc + a_reg;
        a_reg <= a_reg << 1;
        b_reg <= b_reg >> 1;
        count <= count + 5'd1;
      end
      default: begin
        count <= count;
      end
    endcase
  end

  assign req_rdy   = (state == st_idle);
  assign resp_val  = (state == st_done);
  assign resp_data = acc;

endmodule

// File: proc_dpath.sv
// Five-stage processor datapath
// PC and fetch, operand and bypass muxes, ALU and multiplier, write-back

`timescale 1ns/1ns

module proc_dpath #(
  parameter proc_pkg::word_t p_reset_vector = 32'h0000_1000
) (
  input  logic                     clk,
  input  logic                     reset,
  output proc_pkg::word_t          imem_addr,
  input  proc_pkg::word_t          imem_data,
  output proc_pkg::word_t          dmem_addr,
  output proc_pkg::word_t          dmem_wdata,
  input  proc_pkg::word_t          dmem_rdata,
  input  proc_pkg::word_t          from_mngr_data,
  output proc_pkg::word_t          to_mngr_data,
  input  proc_pkg::ctrl_to_dpath_t c,
  output proc_pkg::dpath_to_ctrl_t s,
  input  logic                     mul_req_val,
  input  logic                     mul_resp_rdy,
  output logic                     mul_req_rdy,
  output logic                     mul_resp_val
);

  import proc_pkg::*;

  word_t pc_f, pc_next_f, pc_plus4_f;
  word_t inst_d, pc_plus4_d, imm_sext_d, imm_zext_d;
  word_t br_target_d, j_target_d;
  word_t rf_rdata0, rf_rdata1, rs_val_d, rt_val_d, op0_d, op1_d;
  word_t op0_x, op1_x, wdata_x, br_target_x;
  word_t alu_result_x, mul_result_x, ex_result_x;
  word_t ex_result_m, wb_result_m, wb_result_w;
  logic  br_ne_x;

  // --------------------------------------------------
  // F stage
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset)
      pc_f <= p_reset_vector - 32'd4;
    else if (c.reg_en_f)
      pc_f <= pc_next_f;
  end

  assign pc_plus4_f = pc_f + 32'd4;

  always_comb begin
    case (c.pc_sel)
      pc_br:   pc_next_f = br_target_x;
      pc_j:    pc_next_f = j_target_d;
      pc_jr:   pc_next_f = rs_val_d;
      default: pc_next_f = pc_plus4_f;
    endcase
  end

  // Refetch the same word while F is stalled
  assign imem_addr = c.reg_en_f ? pc_next_f : pc_f;

  // --------------------------------------------------
  // D stage
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset)
      inst_d <= '0;
    else if (c.reg_en_d)
      inst_d <= c.squash_d ? '0 : imem_data;
  end

  always_ff @(posedge clk) begin
    if (c.reg_en_d)
      pc_plus4_d <= pc_plus4_f;
  end

  assign imm_sext_d  = {{16{inst_d[15]}}, inst_d[15:0]};
  assign imm_zext_d  = {16'b0, inst_d[15:0]};
  assign br_target_d = pc_plus4_d + {imm_sext_d[29:0], 2'b00};
  assign j_target_d  = {pc_plus4_d[31:28], inst_d[25:0], 2'b00};

  proc_regfile rf (
    .clk    (clk),
    .reset  (reset),
    .raddr0 (inst_d[25:21]),
    .raddr1 (inst_d[20:16]),
    .waddr  (c.rf_waddr),
    .rdata0 (rf_rdata0),
    .rdata1 (rf_rdata1),
    .wen    (c.rf_wen),
    .wdata  (wb_result_w)
  );

  function automatic word_t byp_mux(byp_sel_t sel, word_t rf_val, word_t x_val,
                                    word_t m_val, word_t w_val);
    case (sel)
      byp_x:   return x_val;
      byp_m:   return m_val;
      byp_w:   return w_val;
      default: return rf_val;
    endcase
  endfunction

  assign rs_val_d = byp_mux(c.byp_rs, rf_rdata0, ex_result_x, wb_result_m, wb_result_w);
  assign rt_val_d = byp_mux(c.byp_rt, rf_rdata1, ex_result_x, wb_result_m, wb_result_w);

  always_comb begin
    case (c.op0_sel)
      op0_shamt: op0_d = {27'b0, inst_d[10:6]};
      op0_zero:  op0_d = '0;
      default:   op0_d = rs_val_d;
    endcase
    case (c.op1_sel)
      op1_simm: op1_d = imm_sext_d;
      op1_zimm: op1_d = imm_zext_d;
      op1_pc4:  op1_d = pc_plus4_d;
      op1_mngr: op1_d = from_mngr_data;
      default:  op1_d = rt_val_d;
    endcase
  end

  // Multiplier takes its operands as mul leaves D
  proc_int_mul mul (
    .clk       (clk),
    .reset     (reset),
    .req_val   (mul_req_val),
    .req_rdy   (mul_req_rdy),
    .req_a     (op0_d),
    .req_b     (op1_d),
    .resp_val  (mul_resp_val),
    .resp_rdy  (mul_resp_rdy),
    .resp_data (mul_result_x)
  );

  // --------------------------------------------------
  // X stage
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (c.reg_en_x) begin
      op0_x       <= op0_d;
      op1_x       <= op1_d;
      wdata_x     <= rt_val_d;
      br_target_x <= br_target_d;
    end
  end

  proc_alu alu (
    .in0 (op0_x),
    .in1 (op1_x),
    .fn  (c.alu_fn),
    .out (alu_result_x),
    .ne  (br_ne_x)
  );

  assign ex_result_x = c.ex_sel_mul ? mul_result_x : alu_result_x;
  assign dmem_addr   = alu_result_x;
  assign dmem_wdata  = wdata_x;

  // --------------------------------------------------
  // M and W stages
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (c.reg_en_m)
      ex_result_m <= ex_result_x;
    if (c.reg_en_w)
      wb_result_w <= wb_result_m;
  end

  // Load data returns one cycle after the X-stage request
  assign wb_result_m  = c.wb_sel_mem ? dmem_rdata : ex_result_m;
  assign to_mngr_data = wb_result_w;

  assign s.inst_d  = inst_d;
  assign s.br_ne_x = br_ne_x;

endmodule

// File: proc_ctrl.sv
// Pipelined control unit: decode, hazard and bypass logic,
// stall/squash enables and the manager and multiplier strobes

`timescale 1ns/1ns

module proc_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  output proc_pkg::ctrl_to_dpath_t c,
  input  proc_pkg::dpath_to_ctrl_t s,
  output logic                     mul_req_val,
  output logic                     mul_resp_rdy,
  input  logic                     mul_req_rdy,
  input  logic                     mul_resp_val,
  output logic                     dmem_wen,
  input  logic                     from_mngr_val,
  output logic                     from_mngr_rdy,
  output logic                     to_mngr_val
);

  import proc_pkg::*;

  // Control carried with an instruction beyond D
  typedef struct packed {
    alu_fn_t   alu_fn;
    logic      is_mul;
    logic      is_lw;
    logic      is_sw;
    logic      is_bne;
    logic      is_mtc0;
    logic      rf_wen;
    reg_addr_t rf_waddr;
  } ctl_t;

  reg_addr_t rs_d, rt_d, rd_d;
  ctl_t      ctl_d, ctl_x, ctl_m, ctl_w;
  op0_sel_t  op0_sel_d;
  op1_sel_t  op1_sel_d;
  logic      uses_rs, uses_rt, is_j_d, is_jr_d, is_mfc0_d;
  logic      val_x, val_m, val_w, fetch_live;
  logic      rs_x, rs_m, rs_w, rt_x, rt_m, rt_w;
  logic      load_use, stall_x, stall_d, go_d, br_taken_x, jump_d;

  assign rs_d = s.inst_d[25:21];
  assign rt_d = s.inst_d[20:16];
  assign rd_d = s.inst_d[15:11];

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------

  always_comb begin
    ctl_d     = '0;
    op0_sel_d = op0_rs;
    op1_sel_d = op1_rt;
    uses_rs   = 1'b0;
    uses_rt   = 1'b0;
    is_j_d    = 1'b0;
    is_jr_d   = 1'b0;
    is_mfc0_d = 1'b0;
    ctl_d.rf_waddr = rt_d;
    case (s.inst_d[31:26])
      op_special: begin
        uses_rs        = 1'b1;
        uses_rt        = 1'b1;
        ctl_d.rf_wen   = 1'b1;
        ctl_d.rf_waddr = rd_d;
        case (s.inst_d[5:0])
          fn_addu: ctl_d.alu_fn = alu_add;
          fn_subu: ctl_d.alu_fn = alu_sub;
          fn_and:  ctl_d.alu_fn = alu_and;
          fn_or:   ctl_d.alu_fn = alu_or;
          fn_slt:  ctl_d.alu_fn = alu_slt;
          fn_sll: begin
            ctl_d.alu_fn = alu_sll;
            op0_sel_d    = op0_shamt;
            uses_rs      = 1'b0;
          end
          fn_jr: begin
            is_jr_d      = 1'b1;
            uses_rt      = 1'b0;
            ctl_d.rf_wen = 1'b0;
          end
          default: ctl_d.rf_wen = 1'b0;
        endcase
      end
      op_addiu, op_lw: begin
        uses_rs      = 1'b1;
        op1_sel_d    = op1_simm;
        ctl_d.rf_wen = 1'b1;
        ctl_d.is_lw  = (s.inst_d[31:26] == op_lw);
      end
      op_ori: begin
        uses_rs      = 1'b1;
        op1_sel_d    = op1_zimm;
        ctl_d.alu_fn = alu_or;
        ctl_d.rf_wen = 1'b1;
      end
      op_lui: begin
        op0_sel_d    = op0_zero;
        op1_sel_d    = op1_zimm;
        ctl_d.alu_fn = alu_lui;
        ctl_d.rf_wen = 1'b1;
      end
      op_sw: begin
        uses_rs     = 1'b1;
        uses_rt     = 1'b1;
        op1_sel_d   = op1_simm;
        ctl_d.is_sw = 1'b1;
      end
      op_bne: begin
        uses_rs      = 1'b1;
        uses_rt      = 1'b1;
        ctl_d.alu_fn = alu_sub;
        ctl_d.is_bne = 1'b1;
      end
      op_j: is_j_d = 1'b1;
      op_cop0: begin
        op0_sel_d = op0_zero;
        if (rs_d == cop0_mt) begin
          uses_rt       = 1'b1;
          ctl_d.is_mtc0 = 1'b1;
        end else if (rs_d == cop0_mf) begin
          op1_sel_d    = op1_mngr;
          is_mfc0_d    = 1'b1;
          ctl_d.rf_wen = 1'b1;
        end
      end
      op_mul: begin
        uses_rs        = 1'b1;
        uses_rt        = 1'b1;
        ctl_d.is_mul   = 1'b1;
        ctl_d.rf_wen   = 1'b1;
        ctl_d.rf_waddr = rd_d;
      end
      default: ctl_d.rf_wen = 1'b0;
    endcase
    // Writes to r0 are dropped here so they never match a source
    if (ctl_d.rf_waddr == '0)
      ctl_d.rf_wen = 1'b0;
  end

  // --------------------------------------------------
  // Hazards and bypass selection
  // --------------------------------------------------

  function automatic logic hit(logic val, ctl_t ctl, reg_addr_t r);
    return val && ctl.rf_wen && (ctl.rf_waddr == r);
  endfunction

  function automatic byp_sel_t byp_pick(logic hx, logic hm, logic hw);
    if (hx)
      return byp_x;
    if (hm)
      return byp_m;
    if (hw)
      return byp_w;
    return byp_none;
  endfunction

  assign rs_x = uses_rs && hit(val_x, ctl_x, rs_d);
  assign rs_m = uses_rs && hit(val_m, ctl_m, rs_d);
  assign rs_w = uses_rs && hit(val_w, ctl_w, rs_d);
  assign rt_x = uses_rt && hit(val_x, ctl_x, rt_d);
  assign rt_m = uses_rt && hit(val_m, ctl_m, rt_d);
  assign rt_w = uses_rt && hit(val_w, ctl_w, rt_d);

  assign load_use   = (rs_x || rt_x) && ctl_x.is_lw;
  assign stall_x    = val_x && ctl_x.is_mul && !mul_resp_val;
  assign br_taken_x = val_x && ctl_x.is_bne && s.br_ne_x;

  // A taken branch overrides any stall of the wrong-path D instruction
  assign stall_d = (stall_x || load_use || (is_mfc0_d && !from_mngr_val) ||
                    (ctl_d.is_mul && !mul_req_rdy)) && !br_taken_x;
  assign go_d    = !stall_d && !br_taken_x;
  assign jump_d  = (is_j_d || is_jr_d) && go_d;

  always_comb begin
    c            = '0;
    c.reg_en_f   = !stall_d;
    c.reg_en_d   = !stall_d;
    c.reg_en_x   = !stall_x;
    c.reg_en_m   = val_x && !stall_x;
    c.reg_en_w   = val_m;
    c.squash_d   = br_taken_x || jump_d || !fetch_live;
    if (br_taken_x)
      c.pc_sel = pc_br;
    else if (jump_d && is_jr_d)
      c.pc_sel = pc_jr;
    else if (jump_d)
      c.pc_sel = pc_j;
    else
      c.pc_sel = pc_plus4;
    c.op0_sel    = op0_sel_d;
    c.op1_sel    = op1_sel_d;
    c.byp_rs     = byp_pick(rs_x, rs_m, rs_w);
    c.byp_rt     = byp_pick(rt_x, rt_m, rt_w);
    c.alu_fn     = ctl_x.alu_fn;
    c.ex_sel_mul = ctl_x.is_mul;
    c.wb_sel_mem = ctl_m.is_lw;
    c.rf_waddr   = ctl_w.rf_waddr;
    c.rf_wen     = val_w && ctl_w.rf_wen;
  end

  // --------------------------------------------------
  // Pipeline valid bits and control registers
  // --------------------------------------------------

  // F holds a real fetch from the second cycle after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_live <= 1'b0;
      val_x      <= 1'b0;
      val_m      <= 1'b0;
      val_w      <= 1'b0;
    end else begin
      fetch_live <= 1'b1;
      if (!stall_x)
        val_x <= go_d;
      val_m <= val_x && !stall_x;
      val_w <= val_m;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_x)
      ctl_x <= ctl_d;
    ctl_m <= ctl_x;
    ctl_w <= ctl_m;
  end

  assign mul_req_val   = ctl_d.is_mul && go_d;
  assign mul_resp_rdy  = val_x && ctl_x.is_mul;
  assign dmem_wen      = val_x && ctl_x.is_sw;
  assign from_mngr_rdy = is_mfc0_d && !stall_x && !load_use && !br_taken_x;
  assign to_mngr_val   = val_w && ctl_w.is_mtc0;

endmodule

// File: proc_top.sv
// Pipelined processor top: control unit and datapath joined
// to the memory and manager ports

`timescale 1ns/1ns

module proc_top #(
  parameter proc_pkg::word_t p_reset_vector = 32'h0000_1000
) (
  input  logic            clk,
  input  logic            reset,
  output proc_pkg::word_t imem_addr,
  input  proc_pkg::word_t imem_data,
  output proc_pkg::word_t dmem_addr,
  output proc_pkg::word_t dmem_wdata,
  output logic            dmem_wen,
  input  proc_pkg::word_t dmem_rdata,
  input  proc_pkg::word_t from_mngr_data,
  input  logic            from_mngr_val,
  output logic            from_mngr_rdy,
  output proc_pkg::word_t to_mngr_data,
  output logic            to_mngr_val
);

  import proc_pkg::*;

  ctrl_to_dpath_t c;
  dpath_to_ctrl_t s;
  logic           mul_req_val;
  logic           mul_req_rdy;
  logic           mul_resp_val;
  logic           mul_resp_rdy;

  proc_ctrl ctrl (
    .clk           (clk),
    .reset         (reset),
    .c             (c),
    .s             (s),
    .mul_req_val   (mul_req_val),
    .mul_resp_rdy  (mul_resp_rdy),
    .mul_req_rdy   (mul_req_rdy),
    .mul_resp_val  (mul_resp_val),
    .dmem_wen      (dmem_wen),
    .from_mngr_val (from_mngr_val),
    .from_mngr_rdy (from_mngr_rdy),
    .to_mngr_val   (to_mngr_val)
  );

  proc_dpath #(
    .p_reset_vector (p_reset_vector)
  ) dpath (
    .clk            (clk),
    .reset          (reset),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .dmem_addr      (dmem_addr),
    .dmem_wdata     (dmem_wdata),
    .dmem_rdata     (dmem_rdata),
    .from_mngr_data (from_mngr_data),
    .to_mngr_data   (to_mngr_data),
    .c              (c),
    .s              (s),
    .mul_req_val    (mul_req_val),
    .mul_resp_rdy   (mul_resp_rdy),
    .mul_req_rdy    (mul_req_rdy),
    .mul_resp_val   (mul_resp_val)
  );

endmodule

// File: proc_tb.sv
// Testbench for the pipelined processor: memory and manager models,
// program assembly, reference model and message checker

`timescale 1ns/1ns

module proc_tb;

  import proc_pkg::*;

  localparam word_t reset_vector = 32'h0000_1000;
  localparam int    num_pairs    = 20;
  localparam int    num_msgs     = 13;
  localparam int    total_msgs   = num_pairs * num_msgs;
  localparam int    max_cycles   = num_pairs * 300 + 200;

  logic  clk;
  logic  reset;
  word_t imem_addr, imem_data;
  word_t dmem_addr, dmem_wdata, dmem_rdata;
  logic  dmem_wen;
  word_t from_mngr_data, to_mngr_data;
  logic  from_mngr_val, from_mngr_rdy, to_mngr_val;

  word_t imem [0:255];
  word_t dmem [0:1023];
  word_t imem_q, dmem_q;
  word_t a_vals [num_pairs];
  word_t b_vals [num_pairs];
  word_t exp_val, seed_draw;
  int    n_inst, n_recv, pair_idx, msg_idx, cycles;
  int    value_errors, other_errors;

  proc_top #(
    .p_reset_vector (reset_vector)
  ) dut (
    .clk            (clk),
    .reset          (reset),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .dmem_addr      (dmem_addr),
    .dmem_wdata     (dmem_wdata),
    .dmem_wen       (dmem_wen),
    .dmem_rdata     (dmem_rdata),
    .from_mngr_data (from_mngr_data),
    .from_mngr_val  (from_mngr_val),
    .from_mngr_rdy  (from_mngr_rdy),
    .to_mngr_data   (to_mngr_data),
    .to_mngr_val    (to_mngr_val)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------
  // Instruction encoders and program assembly
  // --------------------------------------------------

  function automatic word_t rtype(logic [5:0] fn, reg_addr_t rd, reg_addr_t rs,
                                  reg_addr_t rt, logic [4:0] shamt);
    return {op_special, rs, rt, rd, shamt, fn};
  endfunction

  function automatic word_t itype(logic [5:0] op, reg_addr_t rt, reg_addr_t rs,
                                  logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jtype(word_t target);
    return {op_j, target[27:2]};
  endfunction

  function automatic word_t cop0_move(logic [4:0] dir, reg_addr_t rt);
    return {op_cop0, dir, rt, 16'b0};
  endfunction

  function automatic word_t mul_rr(reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
    return {op_mul, rs, rt, rd, 5'b0, 6'h02};
  endfunction

  // Offset counts words from the instruction after the branch
  function automatic word_t bne_to(reg_addr_t rs, reg_addr_t rt, word_t pc, word_t target);
    word_t off;
    off = (target - (pc + 32'd4)) >> 2;
    return {op_bne, rs, rt, off[15:0]};
  endfunction

  function automatic word_t next_addr();
    return reset_vector + (n_inst << 2);
  endfunction

  task automatic place(input word_t inst);
    imem[n_inst] = inst;
    n_inst++;
  endtask

  task automatic build_program();
    int    fix_test, fix_l1, fix_l2;
    word_t loop_addr, body_addr, l2_addr;
    for (int i = 0; i < 256; i++)
      imem[i] = '0;
    n_inst = 0;
    place(itype(op_ori, 5'd20, 5'd0, 16'h2000));   // Data base
    place(itype(op_ori, 5'd21, 5'd0, 16'h000f));   // Count mask
    loop_addr = next_addr();
    place(cop0_move(cop0_mf, 5'd1));
    place(cop0_move(cop0_mf, 5'd2));
    place(rtype(fn_addu, 5'd3, 5'd1, 5'd2, 5'd0));
    place(cop0_move(cop0_mt, 5'd3));
    place(rtype(fn_subu, 5'd4, 5'd2, 5'd3, 5'd0));
    place(rtype(fn_and, 5'd5, 5'd4, 5'd2, 5'd0));
    place(cop0_move(cop0_mt, 5'd4));
    place(cop0_move(cop0_mt, 5'd5));
    place(rtype(fn_or, 5'd6, 5'd5, 5'd1, 5'd0));
    place(rtype(fn_slt, 5'd7, 5'd4, 5'd6, 5'd0));
    place(rtype(fn_sll, 5'd8, 5'd0, 5'd6, 5'd3));
    place(cop0_move(cop0_mt, 5'd6));
    place(cop0_move(cop0_mt, 5'd7));
    place(cop0_move(cop0_mt, 5'd8));
    place(itype(op_ori, 5'd9, 5'd8, 16'h5a5a));
    place(itype(op_lui, 5'd10, 5'd0, 16'h8421));
    place(rtype(fn_addu, 5'd10, 5'd10, 5'd9, 5'd0));
    place(cop0_move(cop0_mt, 5'd9));
    place(cop0_move(cop0_mt, 5'd10));
    place(mul_rr(5'd11, 5'd1, 5'd2));
    place(cop0_move(cop0_mt, 5'd11));
    // Store then dependent load and add
    place(itype(op_sw, 5'd1, 5'd20, 16'h0000));
    place(itype(op_lw, 5'd12, 5'd20, 16'h0000));
    place(rtype(fn_addu, 5'd12, 5'd12, 5'd2, 5'd0));
    place(cop0_move(cop0_mt, 5'd12));
    // Count-down loop summing r14 into r15
    place(rtype(fn_and, 5'd14, 5'd1, 5'd21, 5'd0));
    place(rtype(fn_addu, 5'd15, 5'd0, 5'd0, 5'd0));
    fix_test = n_inst;
    place('0);
    body_addr = next_addr();
    place(rtype(fn_addu, 5'd15, 5'd15, 5'd14, 5'd0));
    place(itype(op_addiu, 5'd14, 5'd14, 16'hffff));
    imem[fix_test] = jtype(next_addr());
    place(bne_to(5'd14, 5'd0, next_addr(), body_addr));
    place(cop0_move(cop0_mt, 5'd15));
    // j and jr, each over an mtc0 that must not run
    place(itype(op_addiu, 5'd16, 5'd1, 16'd7));
    fix_l1 = n_inst;
    place('0);
    place(cop0_move(cop0_mt, 5'd1));
    imem[fix_l1] = jtype(next_addr());
    place(cop0_move(cop0_mt, 5'd16));
    fix_l2 = n_inst;
    place('0);
    place('0);
    place(rtype(fn_jr, 5'd0, 5'd22, 5'd0, 5'd0));
    place(cop0_move(cop0_mt, 5'd2));
    l2_addr = next_addr();
    imem[fix_l2]     = itype(op_lui, 5'd22, 5'd0, l2_addr[31:16]);
    imem[fix_l2 + 1] = itype(op_ori, 5'd22, 5'd22, l2_addr[15:0]);
    place(rtype(fn_addu, 5'd17, 5'd16, 5'd2, 5'd0));
    place(cop0_move(cop0_mt, 5'd17));
    place(jtype(loop_addr));
  endtask

  task automatic fill_data_memory();
    word_t byte_addr;
    for (int i = 0; i < 1024; i++) begin
      byte_addr = i << 2;
      dmem[i] = {~byte_addr[15:0], byte_addr[15:0]};
    end
  endtask

  // --------------------------------------------------
  // Memory and manager models
  // --------------------------------------------------

  // Address taken at the rising edge, data presented at the falling edge
  always @(posedge clk) begin
    imem_q = imem[imem_addr[9:2]];
    dmem_q = dmem[dmem_addr[11:2]];
    if (dmem_wen === 1'b1)
      dmem[dmem_addr[11:2]] = dmem_wdata;
  end

  always @(negedge clk) begin
    imem_data  = imem_q;
    dmem_rdata = dmem_q;
  end

  task automatic send_word(input word_t w);
    int gap;
    gap = $urandom_range(3, 0);
    @(negedge clk);
    if (gap > 0) begin
      from_mngr_val = 1'b0;
      repeat (gap) @(negedge clk);
    end
    from_mngr_data = w;
    from_mngr_val  = 1'b1;
    @(posedge clk);
    while (from_mngr_rdy !== 1'b1)
      @(posedge clk);
  endtask

  // --------------------------------------------------
  // Reference model and checker
  // --------------------------------------------------

  function automatic word_t expected_msg(int idx, word_t a, word_t b);
    word_t sum, neg, andv, orv, shl, oriv, cnt;
    sum  = a + b;
    neg  = b - sum;
    andv = neg & b;
    orv  = andv | a;
    shl  = orv << 3;
    oriv = shl | 32'h0000_5a5a;
    cnt  = {28'b0, a[3:0]};
    case (idx)
      0:  return sum;
      1:  return neg;
      2:  return andv;
      3:  return orv;
      4:  return ($signed(neg) < $signed(orv)) ? 32'd1 : 32'd0;
      5:  return shl;
      6:  return oriv;
      7:  return 32'h8421_0000 + oriv;
      8:  return a * b;
      9:  return a + b;
      10: return (cnt * (cnt + 32'd1)) >> 1;
      11: return a + 32'd7;
      12: return a + 32'd7 + b;
      default: return '0;
    endcase
  endfunction

  function automatic string msg_name(int idx);
    case (idx)
      0:  return "addu";
      1:  return "subu";
      2:  return "and";
      3:  return "or";
      4:  return "slt";
      5:  return "sll";
      6:  return "ori";
      7:  return "lui";
      8:  return "mul";
      9:  return "load_use";
      10: return "branch_loop";
      11: return "jump";
      12: return "jump_reg";
      default: return "unknown";
    endcase
  endfunction

  always @(posedge clk) begin
    if (to_mngr_val === 1'b1) begin
      assert (n_recv < total_msgs) else begin
        other_errors++;
        $display("Unexpected extra manager word %h after all messages", to_mngr_data);
      end
      if (n_recv < total_msgs) begin
        pair_idx = n_recv / num_msgs;
        msg_idx  = n_recv % num_msgs;
        exp_val  = expected_msg(msg_idx, a_vals[pair_idx], b_vals[pair_idx]);
        assert (to_mngr_data === exp_val) else begin
          value_errors++;
          $display("FAIL %s (pair %0d): expected %h, actual %h",
                   msg_name(msg_idx), pair_idx, exp_val, to_mngr_data);
        end
      end
      n_recv++;
    end
  end

  // --------------------------------------------------
  // Main sequence and run limit
  // --------------------------------------------------

  initial begin
    seed_draw      = $urandom(73684);
    reset          = 1'b1;
    from_mngr_val  = 1'b0;
    from_mngr_data = '0;
    imem_data      = '0;
    dmem_rdata     = '0;
    value_errors   = 0;
    other_errors   = 0;
    n_recv         = 0;
    build_program();
    fill_data_memory();
    for (int p = 0; p < num_pairs; p++) begin
      a_vals[p] = $urandom();
      b_vals[p] = $urandom();
    end

    repeat (16) begin
      @(negedge clk);
      assert (to_mngr_val === 1'b0 && dmem_wen === 1'b0 && from_mngr_rdy === 1'b0)
      else begin
        other_errors++;
        $display("Output strobe not low during reset at time %0t", $time);
      end
    end
    reset = 1'b0;
    @(posedge clk);
    assert (imem_addr === reset_vector) else begin
      value_errors++;
      $display("FAIL reset_vector: expected %h, actual %h", reset_vector, imem_addr);
    end

    for (int p = 0; p < num_pairs; p++) begin
      send_word(a_vals[p]);
      send_word(b_vals[p]);
    end
    @(negedge clk);
    from_mngr_val = 1'b0;

    // Wait for the last message, then watch for stray words
    while (n_recv < total_msgs)
      @(negedge clk);
    repeat (20) @(negedge clk);

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d of %0d manager messages received",
             cycles, n_recv, total_msgs);
    $display("Errors: %0d value mismatches, %0d other failures", value_errors,
             other_errors + 1);
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: files.f
proc_pkg.sv
proc_alu.sv
proc_regfile.sv
proc_int_mul.sv
proc_dpath.sv
proc_ctrl.sv
proc_top.sv
proc_tb.sv
